//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_icache -f verilog.f -o sim_icache

output=$(./obj_dir/sim_icache)
echo "$output"

# the run passes only if the testbench printed its pass line
echo "$output" | grep -q "^Simulation finished: PASS$"

//--- sim/icache_checker.sv
// icache strobe checker
// concurrent assertions on the top-level result, miss and fill strobes

module icache_checker (
  input logic clk_i,
  input logic reset_i,
  input logic data_v_i,
  input logic miss_req_v_i,
  input logic miss_i,
  input logic fetch_ready_i,
  input logic fill_v_i,
  input logic fill_yumi_i
);

  timeunit 1ns;
  timeprecision 1ps;

  result_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_i && miss_req_v_i))
    else $error("data_v_o and miss_req_v_o high in the same cycle");

  // a miss request is a single pulse
  request_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_req_v_i |=> !miss_req_v_i)
    else $error("miss_req_v_o high on two consecutive cycles");

  ready_during_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_i |-> !fetch_ready_i)
    else $error("fetch_ready_o high while miss_o is high");

  yumi_needs_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    fill_yumi_i |-> fill_v_i)
    else $error("fill_yumi_o high without fill_v_i");

endmodule

bind icache_top icache_checker u_checker (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .data_v_i      (data_v_o),
  .miss_req_v_i  (miss_req_v_o),
  .miss_i        (miss_o),
  .fetch_ready_i (fetch_ready_o),
  .fill_v_i      (fill_v_i),
  .fill_yumi_i   (fill_yumi_o)
);

//--- sim/tb_icache.sv
// icache testbench
// random fetches against a reference model, with a fill responder for misses

module tb_icache;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_SETS = 8;
  localparam int TIMEOUT = 40;

  logic                      clk_i;
  logic                      reset_i;
  logic                      fetch_v_i;
  logic [31:0]               fetch_addr_i;
  logic                      fetch_ready_o;
  logic [31:0]               data_o;
  logic                      data_v_o;
  logic                      miss_req_v_o;
  logic [31:0]               miss_req_addr_o;
  logic [1:0]                miss_req_way_o;
  logic                      miss_o;
  logic                      fill_done_i;
  logic                      fill_v_i;
  icache_pkg::fill_op_e      fill_op_i;
  logic [2:0]                fill_index_i;
  logic [1:0]                fill_way_i;
  icache_pkg::fill_payload_u fill_payload_i;
  logic                      fill_yumi_o;

  // reference model, block address kept as the tag
  logic [27:0]  m_blk [NUM_SETS][4];
  logic [127:0] m_block [NUM_SETS][4];
  logic [3:0]   m_valid [NUM_SETS];
  logic [2:0]   m_lru [NUM_SETS];

  integer      seed;
  int          errors;
  int          test_errors;
  int          tests_failed;
  bit          hung;
  bit          hold_fetch;
  logic [1:0]  last_miss_way;
  string       test_name;
  logic [31:0] addrs [$];
  int          misses;
  int          inv_way;

  icache_top #(
    .NUM_SETS(NUM_SETS)
  ) u_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_v_i       (fetch_v_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .data_o          (data_o),
    .data_v_o        (data_v_o),
    .miss_req_v_o    (miss_req_v_o),
    .miss_req_addr_o (miss_req_addr_o),
    .miss_req_way_o  (miss_req_way_o),
    .miss_o          (miss_o),
    .fill_done_i     (fill_done_i),
    .fill_v_i        (fill_v_i),
    .fill_op_i       (fill_op_i),
    .fill_index_i    (fill_index_i),
    .fill_way_i      (fill_way_i),
    .fill_payload_i  (fill_payload_i),
    .fill_yumi_o     (fill_yumi_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  function automatic int rand_below(int n);
    return int'(($random(seed) & 32'h7fff_ffff) % n);
  endfunction

  // set bits 6:4, tag above, word in bits 3:2
  function automatic logic [31:0] make_addr(int tag, int set, int word);
    return (tag << 7) | (set << 4) | (word << 2);
  endfunction

  // backing memory content as a function of the word address
  function automatic logic [31:0] mem_word(logic [31:0] word_addr);
    return (word_addr * 32'h9e37_79b1) ^ {word_addr[15:0], word_addr[31:16]};
  endfunction

  function automatic logic [127:0] mem_block(logic [31:0] blk_addr);
    logic [127:0] blk;
    for (int w = 0; w < 4; w++) begin
      blk[32*w +: 32] = mem_word({2'b00, blk_addr[31:2]} + 32'(w));
    end
    return blk;
  endfunction

  function automatic int model_lookup(logic [31:0] addr);
    int way;
    way = -1;
    for (int w = 3; w >= 0; w--) begin
      if (m_valid[addr[6:4]][w] && m_blk[addr[6:4]][w] == addr[31:4]) begin
        way = w;
      end
    end
    return way;
  endfunction

  function automatic logic [1:0] model_victim(int s);
    logic [1:0] victim;
    bit         found;
    found = 1'b0;
    victim = 2'd0;
    for (int w = 3; w >= 0; w--) begin
      if (!m_valid[s][w]) begin
        victim = 2'(w);
        found = 1'b1;
      end
    end
    if (!found && !m_lru[s][0]) begin
      victim = m_lru[s][1] ? 2'd1 : 2'd0;
    end else if (!found) begin
      victim = m_lru[s][2] ? 2'd3 : 2'd2;
    end
    return victim;
  endfunction

  function automatic void model_touch(int s, int way);
    m_lru[s][0] = (way < 2);
    if (way < 2) begin
      m_lru[s][1] = (way == 0);
    end else begin
      m_lru[s][2] = (way == 2);
    end
  endfunction

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) else begin
      $display("Error in %s: %s", test_name, what);
      errors++;
    end
  endtask

  task automatic report_timeout(string what);
    $display("Error in %s: timeout waiting for %s", test_name, what);
    errors++;
    hung = 1'b1;
  endtask

  task automatic check_miss_state();
    check_true(miss_o, "miss_o low before fill_done_i");
    check_true(!fetch_ready_o, "fetch_ready_o high during a miss");
    check_true(!data_v_o && !miss_req_v_o, "result strobe during a miss");
  endtask

  task automatic do_fill(icache_pkg::fill_op_e op, logic [31:0] addr, logic [1:0] way,
                         icache_pkg::fill_payload_u payload, bit in_miss);
    int n;
    if (!hung) begin
      @(posedge clk_i);
      #2;
      fill_v_i = 1'b1;
      fill_op_i = op;
      fill_index_i = addr[6:4];
      fill_way_i = way;
      fill_payload_i = payload;
      fetch_v_i = hold_fetch;
      n = 0;
      @(negedge clk_i);
      while (!fill_yumi_o && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      if (!fill_yumi_o) begin
        report_timeout("fill_yumi_o");
      end else begin
        if (in_miss) begin
          check_miss_state();
        end
        case (op)
          icache_pkg::FILL_WRITE_DATA: m_block[addr[6:4]][way] = payload.data;
          icache_pkg::FILL_SET_TAG: begin
            m_blk[addr[6:4]][way] = payload.tag.tag_addr[31:4];
            m_valid[addr[6:4]][way] = 1'b1;
          end
          icache_pkg::FILL_INVALIDATE: m_valid[addr[6:4]][way] = 1'b0;
          default: ;
        endcase
      end
      @(posedge clk_i);
      #2;
      fill_v_i = 1'b0;
    end
  endtask

  task automatic finish_miss();
    int n;
    if (!hung) begin
      @(posedge clk_i);
      #2;
      fill_done_i = 1'b1;
      @(negedge clk_i);
      check_miss_state();
      @(posedge clk_i);
      #2;
      fill_done_i = 1'b0;
      fetch_v_i = 1'b0;
      n = 0;
      @(negedge clk_i);
      while (miss_o && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      if (miss_o) begin
        report_timeout("miss_o to fall");
      end else begin
        check_true(fetch_ready_o, "fetch_ready_o low after the miss ended");
      end
    end
  endtask

  // memory side of a miss: block, then tag, then done
  task automatic serve_miss(logic [31:0] blk_addr, logic [1:0] way);
    icache_pkg::fill_payload_u p;
    p.data = mem_block(blk_addr);
    do_fill(icache_pkg::FILL_WRITE_DATA, blk_addr, way, p, 1'b1);
    p.data = '0;
    p.tag.tag_addr = blk_addr;
    do_fill(icache_pkg::FILL_SET_TAG, blk_addr, way, p, 1'b1);
    finish_miss();
  endtask

  // results are due two edges after acceptance, replay restarts at a miss
  task automatic fetch_stream(input logic [31:0] list [$], input bit dense, output int n_miss);
    int          idx;
    int          cyc;
    int          wd;
    int          way;
    int          fl_idx [$];
    int          fl_due [$];
    bit          missed;
    logic [31:0] a;
    logic [1:0]  victim;
    n_miss = 0;
    idx = 0;
    cyc = 0;
    while ((idx < list.size() || fl_idx.size() > 0) && !hung) begin
      @(posedge clk_i);
      #2;
      fetch_v_i = (idx < list.size()) && (dense || rand_below(4) != 0);
      fetch_addr_i = (idx < list.size()) ? list[idx] : 32'h0;
      @(negedge clk_i);
      missed = 1'b0;
      if (fl_due.size() > 0 && fl_due[0] == cyc) begin
        a = list[fl_idx[0]];
        way = model_lookup(a);
        if (way >= 0) begin
          wd = int'(a[3:2]);
          check_true(data_v_o && !miss_req_v_o, "no data_v_o for a resident block");
          check_value("data_o", m_block[a[6:4]][way][32*wd +: 32], data_o);
          model_touch(int'(a[6:4]), way);
          void'(fl_idx.pop_front());
          void'(fl_due.pop_front());
        end else begin
          missed = 1'b1;
          victim = model_victim(int'(a[6:4]));
          check_true(miss_req_v_o && !data_v_o, "no miss_req_v_o for a missing block");
          check_value("miss_req_addr_o", {a[31:4], 4'b0000}, miss_req_addr_o);
          check_value("miss_req_way_o", 32'(victim), 32'(miss_req_way_o));
          last_miss_way = miss_req_way_o;
          n_miss++;
          idx = fl_idx[0];
          fl_idx.delete();
          fl_due.delete();
          serve_miss({a[31:4], 4'b0000}, victim);
        end
      end else begin
        check_true(!data_v_o && !miss_req_v_o, "result strobe with no fetch due");
      end
      if (!missed && fetch_v_i && fetch_ready_o) begin
        fl_idx.push_back(idx);
        fl_due.push_back(cyc + 2);
        idx++;
      end
      cyc++;
      if (cyc > 12 * list.size() + TIMEOUT) begin
        report_timeout("fetch results");
      end
    end
    fetch_v_i = 1'b0;
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    if (errors != test_errors) begin
      tests_failed++;
    end
    $display("test %s: %0d errors", test_name, errors - test_errors);
  endtask

  initial begin
    seed = 32'h72d;
    errors = 0;
    tests_failed = 0;
    hung = 1'b0;
    hold_fetch = 1'b0;
    reset_i = 1'b1;
    fetch_v_i = 1'b0;
    fetch_addr_i = '0;
    fill_v_i = 1'b0;
    fill_op_i = icache_pkg::FILL_SET_TAG;
    fill_index_i = '0;
    fill_way_i = '0;
    fill_payload_i = '0;
    fill_done_i = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_lru[s] = '0;
    end
    repeat (10) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    start_test("reset_state");
    @(negedge clk_i);
    check_true(!data_v_o && !miss_req_v_o && !miss_o, "strobe high after reset");
    check_true(fetch_ready_o, "fetch_ready_o low after reset");
    addrs.delete();
    addrs.push_back(make_addr(1, 0, 2));
    fetch_stream(addrs, 1'b1, misses);
    check_value("miss count", 1, misses);
    check_value("first way", 0, 32'(last_miss_way));
    end_test();

    // four ways of set 1, then every word of every block
    start_test("fill_refetch");
    addrs.delete();
    for (int t = 1; t <= 4; t++) begin
      addrs.push_back(make_addr(t, 1, 0));
    end
    fetch_stream(addrs, 1'b0, misses);
    check_value("miss count", 4, misses);
    addrs.delete();
    for (int t = 1; t <= 4; t++) begin
      for (int w = 0; w < 4; w++) begin
        addrs.push_back(make_addr(t, 1, w));
      end
    end
    fetch_stream(addrs, 1'b1, misses);
    check_value("refetch miss count", 0, misses);
    end_test();

    start_test("pipelined");
    addrs.delete();
    for (int i = 0; i < 40; i++) begin
      addrs.push_back(make_addr(1 + rand_below(4), 1, rand_below(4)));
    end
    fetch_stream(addrs, 1'b1, misses);
    check_value("resident miss count", 0, misses);
    addrs.delete();
    addrs.push_back(make_addr(9, 2, 1));
    addrs.push_back(make_addr(2, 1, 3));
    fetch_stream(addrs, 1'b1, misses);
    check_value("miss count behind miss", 1, misses);
    end_test();

    start_test("replacement");
    addrs.delete();
    for (int t = 1; t <= 4; t++) begin
      addrs.push_back(make_addr(t, 3, 0));
    end
    fetch_stream(addrs, 1'b0, misses);
    check_value("cold miss count", 4, misses);
    addrs.delete();
    for (int i = 0; i < 24; i++) begin
      addrs.push_back(make_addr(1 + rand_below(4), 3, rand_below(4)));
    end
    fetch_stream(addrs, 1'b0, misses);
    addrs.delete();
    addrs.push_back(make_addr(7, 3, 1));
    fetch_stream(addrs, 1'b1, misses);
    check_value("eviction miss count", 1, misses);
    addrs.delete();
    for (int i = 0; i < 60; i++) begin
      addrs.push_back(make_addr(1 + rand_below(7), 3 + rand_below(2), rand_below(4)));
    end
    fetch_stream(addrs, 1'b0, misses);
    end_test();

    start_test("invalidate");
    inv_way = model_lookup(make_addr(3, 1, 0));
    check_true(inv_way >= 0, "block not resident before invalidation");
    if (inv_way >= 0) begin
      do_fill(icache_pkg::FILL_INVALIDATE, make_addr(3, 1, 0), 2'(inv_way), '0, 1'b0);
      addrs.delete();
      addrs.push_back(make_addr(3, 1, 2));
      fetch_stream(addrs, 1'b1, misses);
      check_value("miss count", 1, misses);
      check_value("replacement way", 32'(inv_way), 32'(last_miss_way));
    end
    end_test();

    // fetch_v_i stays high during the miss, fills must still be taken
    start_test("miss_tracker");
    hold_fetch = 1'b1;
    addrs.delete();
    addrs.push_back(make_addr(11, 5, 0));
    addrs.push_back(make_addr(12, 5, 3));
    fetch_stream(addrs, 1'b0, misses);
    check_value("miss count", 2, misses);
    hold_fetch = 1'b0;
    end_test();

    $display("tests: 6, failed: %0d, errors: %0d", tests_failed, errors);
    if (errors == 0 && !hung) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src/icache_data_banks.sv
// icache data store
// four word banks with blocks rotated across banks by way number

module icache_data_banks #(
  parameter int NUM_SETS = 64,
  localparam int INDEX_WIDTH = $clog2(NUM_SETS),
  localparam int ROW_WIDTH = INDEX_WIDTH + icache_pkg::WAY_WIDTH
) (
  input  logic                              clk_i,
  input  logic                              lookup_v_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
  input  logic                              fill_we_i,
  input  icache_pkg::fill_op_e              fill_op_i,
  input  logic [INDEX_WIDTH-1:0]            fill_index_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]  fill_way_i,
  input  icache_pkg::fill_payload_u         fill_payload_i,
  output logic [icache_pkg::WORDS_PER_BLOCK-1:0][icache_pkg::INSTR_WIDTH-1:0] bank_words_o
);

  logic [INDEX_WIDTH-1:0]              lookup_index;
  logic [icache_pkg::WAY_WIDTH-1:0]    lookup_word;
  logic                                data_we;
  logic [icache_pkg::WORDS_PER_BLOCK-1:0][icache_pkg::INSTR_WIDTH-1:0] read_words_tl;

  assign lookup_index = fetch_addr_i[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
  assign lookup_word = fetch_addr_i[icache_pkg::OFFSET_WIDTH-1 -: icache_pkg::WAY_WIDTH];
  assign data_we = fill_we_i && (fill_op_i == icache_pkg::FILL_WRITE_DATA);

  for (genvar b = 0; b < icache_pkg::WORDS_PER_BLOCK; b++) begin : g_bank
    localparam logic [icache_pkg::WAY_WIDTH-1:0] BANK_ID = icache_pkg::WAY_WIDTH'(b);

    logic [icache_pkg::INSTR_WIDTH-1:0] mem [NUM_SETS * icache_pkg::WAYS];
    logic [ROW_WIDTH-1:0]               read_row;
    logic [ROW_WIDTH-1:0]               write_row;
    logic [icache_pkg::INSTR_WIDTH-1:0] write_word;
    logic [icache_pkg::INSTR_WIDTH-1:0] read_word_r;

    // word w of way k lives in bank w^k at row {set, k}
    assign read_row = {lookup_index, lookup_word ^ BANK_ID};
    assign write_row = {fill_index_i, fill_way_i};
    assign write_word =
      fill_payload_i.data[(fill_way_i ^ BANK_ID) * icache_pkg::INSTR_WIDTH +:
                          icache_pkg::INSTR_WIDTH];

    always_ff @(posedge clk_i) begin
      if (data_we) begin
        mem[write_row] <= write_word;
      end
      if (lookup_v_i) begin
        read_word_r <= mem[read_row];
      end
    end

    assign read_words_tl[b] = read_word_r;
  end

  // second stage copy of the read words
  always_ff @(posedge clk_i) begin
    bank_words_o <= read_words_tl;
  end

endmodule

//--- src/icache_fetch_ctrl.sv
// icache fetch control
// pipeline valids, hit word select, pseudo-LRU, miss request and tracker

module icache_fetch_ctrl #(
  parameter int NUM_SETS = 64,
  localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              fetch_v_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
  input  logic                              fill_v_i,
  input  logic                              fill_done_i,
  input  logic                              hit_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]  hit_way_i,
  input  logic [icache_pkg::WAYS-1:0]       valid_ways_i,
  input  logic [icache_pkg::WORDS_PER_BLOCK-1:0][icache_pkg::INSTR_WIDTH-1:0] bank_words_i,
  output logic                              lookup_v_o,
  output logic                              fill_we_o,
  output logic                              fetch_ready_o,
  output logic [icache_pkg::INSTR_WIDTH-1:0] data_o,
  output logic                              data_v_o,
  output logic                              miss_req_v_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0] miss_req_addr_o,
  output logic [icache_pkg::WAY_WIDTH-1:0]  miss_req_way_o,
  output logic                              miss_o
);

  logic                               v_tl_r;
  logic                               v_tv_r;
  logic [icache_pkg::ADDR_WIDTH-1:0]  addr_tl_r;
  logic [icache_pkg::ADDR_WIDTH-1:0]  addr_tv_r;
  logic                               miss_r;
  logic [NUM_SETS-1:0][icache_pkg::LRU_WIDTH-1:0] lru_r;

  logic [INDEX_WIDTH-1:0]             index_tv;
  logic [icache_pkg::WAY_WIDTH-1:0]   word_tv;
  logic [icache_pkg::LRU_WIDTH-1:0]   lru_tv;
  logic [icache_pkg::LRU_WIDTH-1:0]   lru_next;
  logic [icache_pkg::WAY_WIDTH-1:0]   lru_victim;
  logic [icache_pkg::WAY_WIDTH-1:0]   invalid_way;
  logic                               invalid_found;

  // fetch wins over fill
  assign fetch_ready_o = ~miss_req_v_o & ~miss_r;
  assign lookup_v_o = fetch_v_i & fetch_ready_o;
  assign fill_we_o = fill_v_i & ~lookup_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
    end else begin
      v_tl_r <= lookup_v_o;
      // the fetch right behind a miss is dropped
      v_tv_r <= v_tl_r & ~miss_req_v_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v_o) begin
      addr_tl_r <= fetch_addr_i;
    end
    if (v_tl_r) begin
      addr_tv_r <= addr_tl_r;
    end
  end

  assign index_tv = addr_tv_r[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
  assign word_tv = addr_tv_r[icache_pkg::OFFSET_WIDTH-1 -: icache_pkg::WAY_WIDTH];

  assign data_v_o = v_tv_r & hit_i;
  assign data_o = bank_words_i[hit_way_i ^ word_tv];

  assign miss_req_v_o = v_tv_r & ~hit_i;
  assign miss_req_addr_o = {addr_tv_r[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_WIDTH],
                            icache_pkg::OFFSET_WIDTH'(0)};
  assign miss_req_way_o = invalid_found ? invalid_way : lru_victim;

  always_comb begin
    invalid_found = 1'b0;
    invalid_way = '0;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
      if (!valid_ways_i[w]) begin
        invalid_found = 1'b1;
        invalid_way = icache_pkg::WAY_WIDTH'(w);
      end
    end
  end

  // tree walk, bit 0 picks the half
  assign lru_tv = lru_r[index_tv];
  always_comb begin
    if (!lru_tv[0]) begin
      lru_victim = lru_tv[1] ? 2'd1 : 2'd0;
    end else begin
      lru_victim = lru_tv[2] ? 2'd3 : 2'd2;
    end
  end

  // point the tree away from the way just hit
  always_comb begin
    lru_next = lru_tv;
    lru_next[0] = ~hit_way_i[1];
    if (!hit_way_i[1]) begin
      lru_next[1] = (hit_way_i == 2'd0);
    end else begin
      lru_next[2] = (hit_way_i == 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lru_r <= '0;
    end else if (data_v_o) begin
      lru_r[index_tv] <= lru_next;
    end
  end

  // miss tracker
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_r <= 1'b0;
    end else if (miss_req_v_o) begin
      miss_r <= 1'b1;
    end else if (fill_done_i) begin
      miss_r <= 1'b0;
    end
  end

  assign miss_o = miss_r;

endmodule

//--- src/icache_pkg.sv
// instruction cache shared definitions
// geometry constants, fill opcodes and the fill payload word

package icache_pkg;

  parameter int ADDR_WIDTH = 32;
  parameter int INSTR_WIDTH = 32;

  // associativity is fixed by the 4-way LRU tree
  parameter int WAYS = 4;
  parameter int WAY_WIDTH = 2;

  parameter int WORDS_PER_BLOCK = 4;
  parameter int BLOCK_WIDTH = WORDS_PER_BLOCK * INSTR_WIDTH;
  parameter int OFFSET_WIDTH = 4;
  parameter int LRU_WIDTH = WAYS - 1;

  typedef enum logic [1:0] {
    FILL_SET_TAG    = 2'd0,
    FILL_WRITE_DATA = 2'd1,
    FILL_INVALIDATE = 2'd2
  } fill_op_e;

  // tag view keeps a full address, the tag array slices off its tag bits
  typedef struct packed {
    logic [BLOCK_WIDTH-ADDR_WIDTH-1:0] pad;
    logic [ADDR_WIDTH-1:0]             tag_addr;
  } fill_tag_s;

  // block view has word 0 in the low bits
  typedef union packed {
    logic [BLOCK_WIDTH-1:0] data;
    fill_tag_s              tag;
  } fill_payload_u;

endpackage

//--- src/icache_tag_array.sv
// icache tag array
// per-set tag memory with valid bits, tag compare and stage-two hit registers

module icache_tag_array #(
  parameter int NUM_SETS = 64,
  localparam int INDEX_WIDTH = $clog2(NUM_SETS),
  localparam int TAG_WIDTH = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               lookup_v_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]  fetch_addr_i,
  input  logic                               fill_we_i,
  input  icache_pkg::fill_op_e               fill_op_i,
  input  logic [INDEX_WIDTH-1:0]             fill_index_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]   fill_way_i,
  input  icache_pkg::fill_payload_u          fill_payload_i,
  output logic                               hit_o,
  output logic [icache_pkg::WAY_WIDTH-1:0]   hit_way_o,
  output logic [icache_pkg::WAYS-1:0]        valid_ways_o
);

  logic [TAG_WIDTH-1:0] tag_mem [NUM_SETS][icache_pkg::WAYS];
  logic [NUM_SETS-1:0][icache_pkg::WAYS-1:0] valid_r;

  logic [INDEX_WIDTH-1:0] lookup_index;
  logic [TAG_WIDTH-1:0]   fill_tag;

  logic                                        lookup_tl_r;
  logic [TAG_WIDTH-1:0]                        fetch_tag_tl_r;
  logic [icache_pkg::WAYS-1:0][TAG_WIDTH-1:0]  way_tags_tl_r;
  logic [icache_pkg::WAYS-1:0]                 way_valid_tl_r;
  logic [icache_pkg::WAYS-1:0]                 match_tl;
  logic                                        hit_tl;
  logic [icache_pkg::WAY_WIDTH-1:0]            hit_way_tl;

  assign lookup_index = fetch_addr_i[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
  assign fill_tag = fill_payload_i.tag.tag_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];

  // sync read of the whole set, fills only land when no lookup is taken
  always_ff @(posedge clk_i) begin
    if (fill_we_i && fill_op_i == icache_pkg::FILL_SET_TAG) begin
      tag_mem[fill_index_i][fill_way_i] <= fill_tag;
    end
    if (lookup_v_i) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        way_tags_tl_r[w] <= tag_mem[lookup_index][w];
      end
      way_valid_tl_r <= valid_r[lookup_index];
      fetch_tag_tl_r <= fetch_addr_i[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (fill_we_i) begin
      case (fill_op_i)
        icache_pkg::FILL_SET_TAG:    valid_r[fill_index_i][fill_way_i] <= 1'b1;
        icache_pkg::FILL_INVALIDATE: valid_r[fill_index_i][fill_way_i] <= 1'b0;
        default: ;
      endcase
    end
  end

  // lowest matching way wins
  always_comb begin
    hit_tl = 1'b0;
    hit_way_tl = '0;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
      match_tl[w] = way_valid_tl_r[w] && (way_tags_tl_r[w] == fetch_tag_tl_r);
      if (match_tl[w]) begin
        hit_tl = 1'b1;
        hit_way_tl = icache_pkg::WAY_WIDTH'(w);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup_tl_r <= 1'b0;
      hit_o <= 1'b0;
    end else begin
      lookup_tl_r <= lookup_v_i;
      if (lookup_tl_r) begin
        hit_o <= hit_tl;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_tl_r) begin
      hit_way_o <= hit_way_tl;
      valid_ways_o <= way_valid_tl_r;
    end
  end

endmodule

//--- src/icache_top.sv
// 4-way set-associative instruction cache
// two-stage lookup with a miss request port and an external fill port

module icache_top #(
  parameter int NUM_SETS = 64,
  localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic                               fetch_v_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]  fetch_addr_i,
  output logic                               fetch_ready_o,
  output logic [icache_pkg::INSTR_WIDTH-1:0] data_o,
  output logic                               data_v_o,

  output logic                               miss_req_v_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0]  miss_req_addr_o,
  output logic [icache_pkg::WAY_WIDTH-1:0]   miss_req_way_o,
  output logic                               miss_o,
  input  logic                               fill_done_i,

  input  logic                               fill_v_i,
  input  icache_pkg::fill_op_e               fill_op_i,
  input  logic [INDEX_WIDTH-1:0]             fill_index_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]   fill_way_i,
  input  icache_pkg::fill_payload_u          fill_payload_i,
  output logic                               fill_yumi_o
);

  logic                               lookup_v;
  logic                               fill_we;
  logic                               hit;
  logic [icache_pkg::WAY_WIDTH-1:0]   hit_way;
  logic [icache_pkg::WAYS-1:0]        valid_ways;
  logic [icache_pkg::WORDS_PER_BLOCK-1:0][icache_pkg::INSTR_WIDTH-1:0] bank_words;

  assign fill_yumi_o = fill_we;

  icache_tag_array #(
    .NUM_SETS(NUM_SETS)
  ) u_tag_array (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lookup_v_i     (lookup_v),
    .fetch_addr_i   (fetch_addr_i),
    .fill_we_i      (fill_we),
    .fill_op_i      (fill_op_i),
    .fill_index_i   (fill_index_i),
    .fill_way_i     (fill_way_i),
    .fill_payload_i (fill_payload_i),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .valid_ways_o   (valid_ways)
  );

  icache_data_banks #(
    .NUM_SETS(NUM_SETS)
  ) u_data_banks (
    .clk_i          (clk_i),
    .lookup_v_i     (lookup_v),
    .fetch_addr_i   (fetch_addr_i),
    .fill_we_i      (fill_we),
    .fill_op_i      (fill_op_i),
    .fill_index_i   (fill_index_i),
    .fill_way_i     (fill_way_i),
    .fill_payload_i (fill_payload_i),
    .bank_words_o   (bank_words)
  );

  icache_fetch_ctrl #(
    .NUM_SETS(NUM_SETS)
  ) u_fetch_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_v_i       (fetch_v_i),
    .fetch_addr_i    (fetch_addr_i),
    .fill_v_i        (fill_v_i),
    .fill_done_i     (fill_done_i),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .valid_ways_i    (valid_ways),
    .bank_words_i    (bank_words),
    .lookup_v_o      (lookup_v),
    .fill_we_o       (fill_we),
    .fetch_ready_o   (fetch_ready_o),
    .data_o          (data_o),
    .data_v_o        (data_v_o),
    .miss_req_v_o    (miss_req_v_o),
    .miss_req_addr_o (miss_req_addr_o),
    .miss_req_way_o  (miss_req_way_o),
    .miss_o          (miss_o)
  );

endmodule

//--- verilog.f
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_banks.sv
src/icache_fetch_ctrl.sv
src/icache_top.sv
sim/icache_checker.sv
sim/tb_icache.sv
